/* common/soc_pkg.sv */
// bus widths, address region codes, register indices and reset values
// shared by the bus decoder, the SRAM bridge and the register block

package soc_pkg;

  // bus data and address widths
  localparam int unsigned XLEN  = 32;
  localparam int unsigned ADR_W = XLEN - 2;
  localparam int unsigned SEL_W = XLEN / 8;

  // word address bits that pick one of four regions
  localparam int unsigned REGION_LO = 20;
  localparam int unsigned REGION_HI = 21;

  // region codes
  // only the register block and the SRAM have hardware behind them
  localparam logic [1:0] REGION_APU = 2'd0;
  localparam logic [1:0] REGION_GEN = 2'd1;
  localparam logic [1:0] REGION_GPU = 2'd2;
  localparam logic [1:0] REGION_RAM = 2'd3;

  // external SRAM geometry
  // 15 word address bits plus one half-word bit give 64K half-words
  localparam int unsigned RAM_WORD_W = 15;
  localparam int unsigned SRAM_AW    = RAM_WORD_W + 1;
  localparam int unsigned SRAM_DW    = 16;

  // register block indices, taken from word address bits 1:0
  localparam logic [1:0] GEN_SCRATCH0 = 2'd0;
  localparam logic [1:0] GEN_SCRATCH1 = 2'd1;
  localparam logic [1:0] GEN_HB_DIV   = 2'd2;
  localparam logic [1:0] GEN_ID       = 2'd3;

  // heartbeat divider after reset
  // gives a heartbeat period of 16 clock cycles
  localparam logic [XLEN-1:0] HB_DIV_RESET = 32'd7;

  // read-only identification word
  localparam logic [XLEN-1:0] SOC_ID = 32'h0E05_0001;

endpackage

/* hw/soc_bus_decoder.sv */
// address decoder for the system bus
// routes the strobe to the register block or the SRAM bridge,
// multiplexes read data and ack, and answers unmapped regions with err

`timescale 1ns/100ps

module soc_bus_decoder import soc_pkg::*; (
  input  logic             clk_i,
  input  logic             arst_n_i,

  // master side
  input  logic [ADR_W-1:0] adr_i,
  input  logic             cyc_i,
  input  logic             stb_i,
  output logic             ack_o,
  output logic             err_o,
  output logic [XLEN-1:0]  dat_o,

  // register block
  output logic             gen_stb_o,
  input  logic             gen_ack_i,
  input  logic [XLEN-1:0]  gen_dat_i,

  // SRAM bridge
  output logic             ram_stb_o,
  input  logic             ram_ack_i,
  input  logic [XLEN-1:0]  ram_dat_i
);

  logic [1:0] region;
  logic       req;
  logic       unmapped;
  logic       err_q;

  assign region = adr_i[REGION_HI:REGION_LO];
  assign req    = cyc_i & stb_i;

  // one-hot slave strobes and the unmapped flag
  always_comb begin
    gen_stb_o = 1'b0;
    ram_stb_o = 1'b0;
    unmapped  = 1'b0;
    case (region)
      REGION_GEN: gen_stb_o = req;
      REGION_RAM: ram_stb_o = req;
      REGION_APU,
      REGION_GPU: unmapped  = 1'b1;
      default:    unmapped  = 1'b1;
    endcase
  end

  // response multiplexer
  // the master holds the address until the response, so the same region
  // bits that routed the strobe also pick the answer
  always_comb begin
    ack_o = 1'b0;
    dat_o = '0;
    case (region)
      REGION_GEN: begin
        ack_o = gen_ack_i;
        dat_o = gen_dat_i;
      end
      REGION_RAM: begin
        ack_o = ram_ack_i;
        dat_o = ram_dat_i;
      end
      default: begin
        ack_o = 1'b0;
        dat_o = '0;
      end
    endcase
  end

  // error pulse for the audio and graphics regions
  // the flag drops in the cycle it is seen, so a held request gets one err
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req & unmapped & ~err_q;
    end
  end

  assign err_o = err_q;

endmodule

/* hw/sram16/wb_sram16.sv */
// bridge from 32-bit bus words to a 16-bit asynchronous SRAM
// each selected half-word takes a setup cycle and a strobe cycle,
// read halves are gathered into a word register before ack

`timescale 1ns/100ps

module wb_sram16 import soc_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // bus slave side
  input  logic [RAM_WORD_W-1:0] adr_i,
  input  logic [XLEN-1:0]       dat_i,
  input  logic [SEL_W-1:0]      sel_i,
  input  logic                  we_i,
  input  logic                  stb_i,
  output logic [XLEN-1:0]       dat_o,
  output logic                  ack_o,

  // SRAM pins, all controls active low
  output logic [SRAM_AW-1:0]    sram_addr_o,
  input  logic [SRAM_DW-1:0]    sram_dat_i,
  output logic [SRAM_DW-1:0]    sram_dat_o,
  output logic                  sram_we_n_o,
  output logic                  sram_ce_n_o,
  output logic                  sram_oe_n_o,
  output logic                  sram_lb_n_o,
  output logic                  sram_ub_n_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LO_SET,
    S_LO_STB,
    S_HI_SET,
    S_HI_STB
  } state_t;

  state_t             state_q;
  state_t             state_d;
  logic               ack_d;
  logic               ack_q;
  logic               lo_sel;
  logic               hi_sel;
  logic               nxt_active;
  logic               nxt_hi;
  logic               nxt_strobe;
  logic [XLEN-1:0]    rdata_q;

  assign lo_sel = |sel_i[1:0];
  assign hi_sel = |sel_i[3:2];

  // half-word sequencer
  // a new request is only taken when no ack is pending, since the master
  // still holds stb during the ack cycle
  always_comb begin
    state_d = state_q;
    ack_d   = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (stb_i && !ack_q) begin
          if (lo_sel) begin
            state_d = S_LO_SET;
          end else if (hi_sel) begin
            state_d = S_HI_SET;
          end else begin
            // nothing selected, answer at once
            ack_d = 1'b1;
          end
        end
      end
      S_LO_SET: state_d = S_LO_STB;
      S_LO_STB: begin
        if (hi_sel) begin
          state_d = S_HI_SET;
        end else begin
          state_d = S_IDLE;
          ack_d   = 1'b1;
        end
      end
      S_HI_SET: state_d = S_HI_STB;
      S_HI_STB: begin
        state_d = S_IDLE;
        ack_d   = 1'b1;
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= ack_d;
    end
  end

  assign nxt_active = (state_d != S_IDLE);
  assign nxt_hi     = (state_d == S_HI_SET) || (state_d == S_HI_STB);
  assign nxt_strobe = (state_d == S_LO_STB) || (state_d == S_HI_STB);

  // SRAM controls are registered from the next state so the pins
  // never see decode glitches
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sram_ce_n_o <= 1'b1;
      sram_we_n_o <= 1'b1;
      sram_oe_n_o <= 1'b1;
      sram_lb_n_o <= 1'b1;
      sram_ub_n_o <= 1'b1;
    end else begin
      sram_ce_n_o <= ~nxt_active;
      sram_we_n_o <= ~(nxt_strobe & we_i);
      sram_oe_n_o <= ~(nxt_active & ~we_i);
      sram_lb_n_o <= ~(nxt_active & (nxt_hi ? sel_i[2] : sel_i[0]));
      sram_ub_n_o <= ~(nxt_active & (nxt_hi ? sel_i[3] : sel_i[1]));
    end
  end

  // address and write data follow the half being worked on
  always_ff @(posedge clk_i) begin
    sram_addr_o <= {adr_i, nxt_hi};
    sram_dat_o  <= nxt_hi ? dat_i[31:16] : dat_i[15:0];
  end

  // read data is sampled at the end of the strobe cycle
  always_ff @(posedge clk_i) begin
    if (!we_i && state_q == S_LO_STB) begin
      rdata_q[15:0] <= sram_dat_i;
    end
    if (!we_i && state_q == S_HI_STB) begin
      rdata_q[31:16] <= sram_dat_i;
    end
  end

  assign dat_o = rdata_q;
  assign ack_o = ack_q;

endmodule

/* hw/soc_gen_regs.sv */
// general register block
// two scratch words, the heartbeat divider, a read-only ID word
// and the heartbeat generator driven by the divider

`timescale 1ns/100ps

module soc_gen_regs import soc_pkg::*; (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic [1:0]       idx_i,
  input  logic [XLEN-1:0]  dat_i,
  input  logic [SEL_W-1:0] sel_i,
  input  logic             we_i,
  input  logic             stb_i,
  output logic [XLEN-1:0]  dat_o,
  output logic             ack_o,
  output logic             hb_o
);

  logic [XLEN-1:0] scratch0_q;
  logic [XLEN-1:0] scratch1_q;
  logic [XLEN-1:0] hb_div_q;
  logic [XLEN-1:0] hb_cnt_q;
  logic [XLEN-1:0] rdata_q;
  logic            ack_q;
  logic            access;
  logic            wr;

  // replaces only the bytes whose select bit is set
  function automatic logic [XLEN-1:0] merge_bytes(
    input logic [XLEN-1:0]  old_val,
    input logic [XLEN-1:0]  new_val,
    input logic [SEL_W-1:0] sel
  );
    logic [XLEN-1:0] res;
    res = old_val;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // the strobe stays high during the ack cycle, so it is acted on once
  assign access = stb_i & ~ack_q;
  assign wr     = access & we_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q      <= 1'b0;
      scratch0_q <= '0;
      scratch1_q <= '0;
      hb_div_q   <= HB_DIV_RESET;
    end else begin
      ack_q <= access;
      if (wr) begin
        case (idx_i)
          GEN_SCRATCH0: scratch0_q <= merge_bytes(scratch0_q, dat_i, sel_i);
          GEN_SCRATCH1: scratch1_q <= merge_bytes(scratch1_q, dat_i, sel_i);
          GEN_HB_DIV:   hb_div_q   <= merge_bytes(hb_div_q, dat_i, sel_i);
          default:      ;
        endcase
      end
    end
  end

  // read data is captured together with the ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (idx_i)
        GEN_SCRATCH0: rdata_q <= scratch0_q;
        GEN_SCRATCH1: rdata_q <= scratch1_q;
        GEN_HB_DIV:   rdata_q <= hb_div_q;
        GEN_ID:       rdata_q <= SOC_ID;
        default:      rdata_q <= '0;
      endcase
    end
  end

  // heartbeat toggles every divider+1 cycles
  // a new divider value restarts the count
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hb_cnt_q <= '0;
      hb_o     <= 1'b0;
    end else if (wr && idx_i == GEN_HB_DIV) begin
      hb_cnt_q <= '0;
    end else if (hb_cnt_q == hb_div_q) begin
      hb_cnt_q <= '0;
      hb_o     <= ~hb_o;
    end else begin
      hb_cnt_q <= hb_cnt_q + 1'b1;
    end
  end

  assign dat_o = rdata_q;
  assign ack_o = ack_q;

endmodule

/* hw/soc_top.sv */
// top level of the memory and peripheral side
// exposes the bus master port, the SRAM pins and the heartbeat,
// and connects the decoder to the SRAM bridge and the register block

`timescale 1ns/100ps

module soc_top import soc_pkg::*; (
  input  logic               clk_i,
  input  logic               arst_n_i,

  // bus master port
  input  logic [ADR_W-1:0]   wb_adr_i,
  input  logic [XLEN-1:0]    wb_dat_i,
  output logic [XLEN-1:0]    wb_dat_o,
  input  logic [SEL_W-1:0]   wb_sel_i,
  input  logic               wb_we_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  output logic               wb_ack_o,
  output logic               wb_err_o,

  // external SRAM
  output logic [SRAM_AW-1:0] sram_addr_o,
  input  logic [SRAM_DW-1:0] sram_dat_i,
  output logic [SRAM_DW-1:0] sram_dat_o,
  output logic               sram_we_n_o,
  output logic               sram_ce_n_o,
  output logic               sram_oe_n_o,
  output logic               sram_lb_n_o,
  output logic               sram_ub_n_o,

  output logic               hb_o
);

  logic            gen_stb;
  logic            gen_ack;
  logic [XLEN-1:0] gen_dat;
  logic            ram_stb;
  logic            ram_ack;
  logic [XLEN-1:0] ram_dat;

  soc_bus_decoder u_decoder (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .adr_i     (wb_adr_i),
    .cyc_i     (wb_cyc_i),
    .stb_i     (wb_stb_i),
    .ack_o     (wb_ack_o),
    .err_o     (wb_err_o),
    .dat_o     (wb_dat_o),
    .gen_stb_o (gen_stb),
    .gen_ack_i (gen_ack),
    .gen_dat_i (gen_dat),
    .ram_stb_o (ram_stb),
    .ram_ack_i (ram_ack),
    .ram_dat_i (ram_dat)
  );

  // the bridge sees only the word index inside the SRAM
  wb_sram16 u_sram16 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .adr_i       (wb_adr_i[RAM_WORD_W-1:0]),
    .dat_i       (wb_dat_i),
    .sel_i       (wb_sel_i),
    .we_i        (wb_we_i),
    .stb_i       (ram_stb),
    .dat_o       (ram_dat),
    .ack_o       (ram_ack),
    .sram_addr_o (sram_addr_o),
    .sram_dat_i  (sram_dat_i),
    .sram_dat_o  (sram_dat_o),
    .sram_we_n_o (sram_we_n_o),
    .sram_ce_n_o (sram_ce_n_o),
    .sram_oe_n_o (sram_oe_n_o),
    .sram_lb_n_o (sram_lb_n_o),
    .sram_ub_n_o (sram_ub_n_o)
  );

  soc_gen_regs u_gen_regs (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .idx_i    (wb_adr_i[1:0]),
    .dat_i    (wb_dat_i),
    .sel_i    (wb_sel_i),
    .we_i     (wb_we_i),
    .stb_i    (gen_stb),
    .dat_o    (gen_dat),
    .ack_o    (gen_ack),
    .hb_o     (hb_o)
  );

endmodule

/* verif/sram16_model.sv */
// behavioral 64K x 16 asynchronous SRAM with byte lanes
// writes on the rising clock edge, reads combinationally

`timescale 1ns/100ps

module sram16_model import soc_pkg::*; (
  input  logic               clk_i,
  input  logic [SRAM_AW-1:0] addr_i,
  input  logic [SRAM_DW-1:0] dat_i,
  output logic [SRAM_DW-1:0] dat_o,
  input  logic               we_n_i,
  input  logic               ce_n_i,
  input  logic               oe_n_i,
  input  logic               lb_n_i,
  input  logic               ub_n_i
);

  logic [SRAM_DW-1:0] mem [0:(1 << SRAM_AW) - 1];

  // power-up contents, every address holds a different value
  initial begin
    for (int a = 0; a < (1 << SRAM_AW); a++) begin
      mem[a] = {a[7:0], a[15:8]} ^ 16'ha55a;
    end
  end

  always @(posedge clk_i) begin
    if (!ce_n_i && !we_n_i) begin
      if (!lb_n_i) begin
        mem[addr_i][7:0] <= dat_i[7:0];
      end
      if (!ub_n_i) begin
        mem[addr_i][15:8] <= dat_i[15:8];
      end
    end
  end

  // the split data bus reads as zero while the outputs are disabled
  assign dat_o = (!ce_n_i && !oe_n_i) ? mem[addr_i] : '0;

endmodule

/* verif/soc_properties.sv */
// bus protocol assertions for the address decoder
// checks the response pulses and the one-hot slave strobes

`timescale 1ns/100ps

module soc_properties import soc_pkg::*; (
  input logic             clk_i,
  input logic             arst_n_i,
  input logic [ADR_W-1:0] adr_i,
  input logic             cyc_i,
  input logic             stb_i,
  input logic             ack_i,
  input logic             err_i,
  input logic             gen_stb_i,
  input logic             ram_stb_i
);

  int   fail_cnt = 0;
  logic unmapped;

  assign unmapped = (adr_i[REGION_HI:REGION_LO] == REGION_APU) ||
                    (adr_i[REGION_HI:REGION_LO] == REGION_GPU);

  a_resp_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ack_i && err_i))
    else begin
      fail_cnt++;
      $error("ack and err are high together");
    end

  a_resp_in_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ack_i || err_i) |-> (cyc_i && stb_i))
    else begin
      fail_cnt++;
      $error("response seen without an active strobe");
    end

  a_stb_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({gen_stb_i, ram_stb_i}))
    else begin
      fail_cnt++;
      $error("more than one slave strobe is high");
    end

  // a fresh request to a region without hardware is answered next cycle
  a_unmapped_err: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cyc_i && stb_i && unmapped && !err_i) |=> err_i)
    else begin
      fail_cnt++;
      $error("unmapped request got no err one cycle later");
    end

endmodule

/* verif/soc_tb.sv */
// testbench for the memory and peripheral side
// plays the bus master with random requests and compares the
// responses against a reference model of the SRAM and registers

`timescale 1ns/100ps

module soc_tb import soc_pkg::*; ();

  localparam int  CLK_PERIOD     = 4;
  localparam real DRIVE_DELAY    = 0.5;
  localparam int  RESET_CYCLES   = 10;
  localparam int  N_POOL         = 8;
  localparam int  N_RAM_WR       = 32;
  localparam int  N_REG          = 16;
  localparam int  N_UNMAPPED     = 8;
  localparam int  RESP_LIMIT     = 8;
  localparam int  HB_MAX_DIV     = 17;
  localparam int  HB_TOGGLES     = 4;
  localparam int  N_TX           = 3 + 2 * N_POOL + N_RAM_WR + 2 + 2 * N_REG + 3 + N_UNMAPPED + 2;
  localparam int  HB_TEST_CYCLES = (HB_MAX_DIV + 1) * (HB_TOGGLES + 3);
  localparam int  TIMEOUT_CYCLES = RESET_CYCLES + N_TX * 10 + HB_TEST_CYCLES;

  logic clk_i = 1'b0;
  logic arst_n_i;
  logic [ADR_W-1:0] wb_adr;
  logic [XLEN-1:0] wb_wdat;
  logic [XLEN-1:0] wb_rdat;
  logic [SEL_W-1:0] wb_sel;
  logic wb_we;
  logic wb_cyc;
  logic wb_stb;
  logic wb_ack;
  logic wb_err;
  logic [SRAM_AW-1:0] sram_addr;
  logic [SRAM_DW-1:0] sram_rd;
  logic [SRAM_DW-1:0] sram_wr;
  logic sram_we_n;
  logic sram_ce_n;
  logic sram_oe_n;
  logic sram_lb_n;
  logic sram_ub_n;
  logic hb;

  // reference model
  logic [XLEN-1:0] ram_model [int];
  logic [XLEN-1:0] scratch_model [2];
  logic [XLEN-1:0] div_model;
  logic [RAM_WORD_W-1:0] pool [N_POOL];

  integer seed;
  int n_checks = 0;
  int n_errors = 0;
  logic [XLEN-1:0] rdata;
  logic [XLEN-1:0] wdata;
  logic [SEL_W-1:0] sel;
  logic is_err;
  int lat;
  int k;
  int c;
  int last;
  int n_toggles;
  logic prev_hb;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  soc_top dut (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .wb_adr_i (wb_adr), .wb_dat_i (wb_wdat), .wb_dat_o (wb_rdat), .wb_sel_i (wb_sel),
    .wb_we_i (wb_we), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
    .wb_ack_o (wb_ack), .wb_err_o (wb_err),
    .sram_addr_o (sram_addr), .sram_dat_i (sram_rd), .sram_dat_o (sram_wr),
    .sram_we_n_o (sram_we_n), .sram_ce_n_o (sram_ce_n), .sram_oe_n_o (sram_oe_n),
    .sram_lb_n_o (sram_lb_n), .sram_ub_n_o (sram_ub_n), .hb_o (hb)
  );

  sram16_model u_sram (
    .clk_i (clk_i), .addr_i (sram_addr), .dat_i (sram_wr), .dat_o (sram_rd),
    .we_n_i (sram_we_n), .ce_n_i (sram_ce_n), .oe_n_i (sram_oe_n),
    .lb_n_i (sram_lb_n), .ub_n_i (sram_ub_n)
  );

  bind soc_bus_decoder soc_properties u_props (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .adr_i (adr_i), .cyc_i (cyc_i), .stb_i (stb_i),
    .ack_i (ack_o), .err_i (err_o), .gen_stb_i (gen_stb_o), .ram_stb_i (ram_stb_o)
  );

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  function automatic logic [ADR_W-1:0] make_adr(input logic [1:0] region,
                                                input logic [19:0] offset);
    return {8'd0, region, offset};
  endfunction

  // each enable widens into a byte of ones that picks the new bits
  function automatic logic [XLEN-1:0] apply_byte_enables(input logic [XLEN-1:0] old_val,
      input logic [XLEN-1:0] new_val, input logic [SEL_W-1:0] be);
    logic [XLEN-1:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  // one ack cycle plus two SRAM cycles for each half with a byte selected
  function automatic int expected_ram_latency(input logic [SEL_W-1:0] be);
    return 1 + ((|be[1:0]) ? 2 : 0) + ((|be[3:2]) ? 2 : 0);
  endfunction

  // called just after a rising edge, returns at the same point
  task automatic bus_access(input logic [ADR_W-1:0] adr, input logic we,
      input logic [SEL_W-1:0] be, input logic [XLEN-1:0] wd,
      output logic [XLEN-1:0] rd, output logic got_err, output int cycles);
    int n;
    logic done;
    n = 0;
    done = 1'b0;
    got_err = 1'b0;
    rd = '0;
    cycles = -1;
    wb_adr = adr;
    wb_we = we;
    wb_sel = be;
    wb_wdat = wd;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    while (!done && n < RESP_LIMIT) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      n++;
      if (wb_ack || wb_err) begin
        done = 1'b1;
        got_err = wb_err;
        rd = wb_rdat;
        cycles = n;
        if (wb_ack && wb_err) begin
          n_errors++;
          $display("request to %h got ack and err at once", adr);
        end
      end
    end
    if (!done) begin
      n_errors++;
      $display("request to %h got no response within %0d cycles", adr, RESP_LIMIT);
    end
    // the request stays up over the edge where the response is taken
    @(posedge clk_i);
    #(DRIVE_DELAY);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    check_equal("wb_ack_o after response", wb_ack, 1'b0);
    check_equal("wb_err_o after response", wb_err, 1'b0);
    @(posedge clk_i);
    #(DRIVE_DELAY);
  endtask

  task automatic check_response(input logic got_err, input int cycles,
                                input logic exp_err, input int exp_cycles);
    check_equal("wb_err_o", got_err, exp_err);
    check_equal("response latency", cycles, exp_cycles);
  endtask

  initial begin
    seed = 32'h5e46;
    arst_n_i = 1'b0;
    wb_adr = '0;
    wb_wdat = '0;
    wb_sel = '0;
    wb_we = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    arst_n_i = 1'b1;

    check_equal("wb_ack_o", wb_ack, 1'b0);
    check_equal("wb_err_o", wb_err, 1'b0);
    check_equal("hb_o", hb, 1'b0);
    check_equal("sram_ce_n_o", sram_ce_n, 1'b1);
    check_equal("sram_we_n_o", sram_we_n, 1'b1);
    check_equal("sram_oe_n_o", sram_oe_n, 1'b1);
    check_equal("sram_lb_n_o", sram_lb_n, 1'b1);
    check_equal("sram_ub_n_o", sram_ub_n, 1'b1);
    bus_access(make_adr(REGION_GEN, GEN_HB_DIV), 1'b0, 4'hf, '0, rdata, is_err, lat);
    check_response(is_err, lat, 1'b0, 1);
    check_equal("wb_dat_o hb_div", rdata, HB_DIV_RESET);

    // full words first, then partial writes on top of them
    for (int i = 0; i < N_POOL; i++) begin
      pool[i] = $random(seed);
      wdata = $random(seed);
      bus_access(make_adr(REGION_RAM, pool[i]), 1'b1, 4'hf, wdata, rdata, is_err, lat);
      check_response(is_err, lat, 1'b0, 5);
      ram_model[pool[i]] = wdata;
    end
    for (int i = 0; i < N_RAM_WR; i++) begin
      k = $random(seed) & (N_POOL - 1);
      sel = $random(seed);
      wdata = $random(seed);
      bus_access(make_adr(REGION_RAM, pool[k]), 1'b1, sel, wdata, rdata, is_err, lat);
      check_response(is_err, lat, 1'b0, expected_ram_latency(sel));
      ram_model[pool[k]] = apply_byte_enables(ram_model[pool[k]], wdata, sel);
    end
    for (int i = 0; i < N_POOL; i++) begin
      bus_access(make_adr(REGION_RAM, pool[i]), 1'b0, 4'hf, '0, rdata, is_err, lat);
      check_response(is_err, lat, 1'b0, 5);
      check_equal("wb_dat_o ram", rdata, ram_model[pool[i]]);
    end

    for (int i = 0; i < 2; i++) begin
      scratch_model[i] = $random(seed);
      bus_access(make_adr(REGION_GEN, i), 1'b1, 4'hf, scratch_model[i], rdata, is_err, lat);
      check_response(is_err, lat, 1'b0, 1);
    end
    for (int i = 0; i < N_REG; i++) begin
      k = $random(seed) & 1;
      sel = $random(seed);
      wdata = $random(seed);
      bus_access(make_adr(REGION_GEN, k), 1'b1, sel, wdata, rdata, is_err, lat);
      check_response(is_err, lat, 1'b0, 1);
      scratch_model[k] = apply_byte_enables(scratch_model[k], wdata, sel);
      bus_access(make_adr(REGION_GEN, k), 1'b0, 4'hf, '0, rdata, is_err, lat);
      check_response(is_err, lat, 1'b0, 1);
      check_equal("wb_dat_o scratch", rdata, scratch_model[k]);
    end
    bus_access(make_adr(REGION_GEN, GEN_ID), 1'b0, 4'hf, '0, rdata, is_err, lat);
    check_equal("wb_dat_o id", rdata, SOC_ID);
    bus_access(make_adr(REGION_GEN, GEN_ID), 1'b1, 4'hf, $random(seed), rdata, is_err, lat);
    check_response(is_err, lat, 1'b0, 1);
    bus_access(make_adr(REGION_GEN, GEN_ID), 1'b0, 4'hf, '0, rdata, is_err, lat);
    check_equal("wb_dat_o id after write", rdata, SOC_ID);

    for (int i = 0; i < N_UNMAPPED; i++) begin
      bus_access(make_adr(($random(seed) & 1) ? REGION_GPU : REGION_APU, $random(seed)),
                 $random(seed), $random(seed), $random(seed), rdata, is_err, lat);
      check_response(is_err, lat, 1'b1, 1);
    end

    div_model = 2 + ($random(seed) & 15);
    bus_access(make_adr(REGION_GEN, GEN_HB_DIV), 1'b1, 4'hf, div_model, rdata, is_err, lat);
    bus_access(make_adr(REGION_GEN, GEN_HB_DIV), 1'b0, 4'hf, '0, rdata, is_err, lat);
    check_equal("wb_dat_o hb_div", rdata, div_model);
    prev_hb = hb;
    n_toggles = 0;
    last = 0;
    for (c = 1; c <= HB_TEST_CYCLES && n_toggles <= HB_TOGGLES; c++) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      if (hb !== prev_hb) begin
        if (n_toggles > 0) check_equal("hb_o toggle interval", c - last, div_model + 1);
        last = c;
        n_toggles++;
        prev_hb = hb;
      end
    end
    if (n_toggles <= HB_TOGGLES) begin
      n_errors++;
      $display("heartbeat toggled only %0d times in %0d cycles", n_toggles, HB_TEST_CYCLES);
    end

    $display("checks: %0d  errors: %0d  assertion failures: %0d", n_checks, n_errors,
             dut.u_decoder.u_props.fail_cnt);
    if (n_errors == 0 && dut.u_decoder.u_props.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog sized from the transaction count and the heartbeat test
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

/* flist.f */
common/soc_pkg.sv
hw/soc_bus_decoder.sv
hw/sram16/wb_sram16.sv
hw/soc_gen_regs.sv
hw/soc_top.sv
verif/sram16_model.sv
verif/soc_properties.sv
verif/soc_tb.sv
